// ==== Makefile ====
SIM      := verilator
TOP      := tbBusController
FILELIST := src.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJDIR   := obj_dir

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// ==== rtl/busController.sv ====
`timescale 1ns/1ps
`default_nettype none

module busController #(
    parameter int BlockWords = 2
) (
    input  wire                    CLK,
    input  wire                    nRST,
    input  wire busPkg::cacheReq_t cacheReq [2],
    output busPkg::cacheRsp_t      cacheRsp [2],
    output ramPkg::ramReq_t        ramReq,
    input  wire ramPkg::ramState_t ramState,
    input  wire busPkg::word_t     ramload
);

    localparam int IdxW = (BlockWords > 1) ? $clog2(BlockWords) : 1;

    busPkg::busOp_t   op;
    busPkg::coreSel_t owner;
    logic             start;
    logic             step;
    logic             writeMiss;
    logic [IdxW-1:0]  wordIdx;
    logic             lastWord;

    coherenceFsm i_fsm (
        .CLK       (CLK),
        .nRST      (nRST),
        .cacheReq  (cacheReq),
        .ramState  (ramState),
        .lastWord  (lastWord),
        .op        (op),
        .owner     (owner),
        .start     (start),
        .step      (step),
        .writeMiss (writeMiss)
    );

    wordCounter #(.BlockWords(BlockWords)) i_counter (
        .CLK      (CLK),
        .nRST     (nRST),
        .start    (start),
        .step     (step),
        .wordIdx  (wordIdx),
        .lastWord (lastWord)
    );

    ramPortMux #(.BlockWords(BlockWords)) i_ramMux (
        .op       (op),
        .owner    (owner),
        .wordIdx  (wordIdx),
        .cacheReq (cacheReq),
        .ramReq   (ramReq)
    );

    cacheResponder #(.BlockWords(BlockWords)) i_responder (
        .op        (op),
        .owner     (owner),
        .writeMiss (writeMiss),
        .wordIdx   (wordIdx),
        .ramState  (ramState),
        .ramload   (ramload),
        .cacheReq  (cacheReq),
        .cacheRsp  (cacheRsp)
    );

endmodule

`default_nettype wire

// ==== rtl/busPkg.sv ====
`default_nettype none

package busPkg;

    typedef logic [31:0] word_t;

    // byte address, bits 1:0 always zero
    typedef logic [31:0] addr_t;

    // picks core 0 or core 1
    typedef logic coreSel_t;

    typedef enum logic [2:0] {
        opNone,
        opFetch,
        opSnoop,
        opFlush,
        opFill,
        opWriteBack
    } busOp_t;

    // from one core to the controller
    typedef struct packed {
        logic  iREN;
        addr_t iaddr;
        logic  dREN;
        logic  dWEN;
        addr_t daddr;
        word_t dstore;
        logic  ccwrite;
        logic  cctrans;
    } cacheReq_t;

    // from the controller back to one core
    typedef struct packed {
        logic  iwait;
        word_t iload;
        logic  dwait;
        word_t dload;
        logic  ccwait;
        logic  ccinv;
        addr_t ccsnoopaddr;
    } cacheRsp_t;

endpackage

`default_nettype wire

// ==== rtl/cacheResponder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheResponder #(
    parameter int BlockWords = 2,
    localparam int IdxW = (BlockWords > 1) ? $clog2(BlockWords) : 1
) (
    input  wire busPkg::busOp_t    op,
    input  wire busPkg::coreSel_t  owner,
    input  wire                    writeMiss,
    input  wire [IdxW-1:0]         wordIdx,
    input  wire ramPkg::ramState_t ramState,
    input  wire busPkg::word_t     ramload,
    input  wire busPkg::cacheReq_t cacheReq [2],
    output busPkg::cacheRsp_t      cacheRsp [2]
);

    localparam busPkg::addr_t IdxMask = busPkg::addr_t'((BlockWords - 1) << 2);

    logic [1:0]    isOwner;
    logic [1:0]    isPeer;
    logic          ramDone;
    logic          dataDone;
    logic          peerHeld;
    busPkg::addr_t blockBase;
    busPkg::addr_t snoopAddr;

    assign isOwner   = owner ? 2'b10 : 2'b01;
    assign isPeer    = ~isOwner;
    assign ramDone   = (ramState == ramPkg::ramAccess);
    assign dataDone  = ramDone && (op inside {busPkg::opFill, busPkg::opWriteBack});
    assign blockBase = cacheReq[owner].daddr & ~IdxMask;

    // peer stays stalled through snoop and flush, and through a write-miss fill
    assign peerHeld = (op inside {busPkg::opSnoop, busPkg::opFlush})
                   || (op == busPkg::opFill && writeMiss);

    // flush walks the block word by word
    assign snoopAddr = (op == busPkg::opFlush)
                     ? (blockBase | (busPkg::addr_t'(wordIdx) << 2))
                     : blockBase;

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            cacheRsp[c] = '0;
            cacheRsp[c].iwait = cacheReq[c].iREN
                && !(isOwner[c] && op == busPkg::opFetch && ramDone);
            cacheRsp[c].dwait = (cacheReq[c].dREN || cacheReq[c].dWEN)
                && !(isOwner[c] && dataDone);
            if (isOwner[c] && op == busPkg::opFetch) begin
                cacheRsp[c].iload = ramload;
            end
            if (isOwner[c] && op == busPkg::opFill) begin
                cacheRsp[c].dload = ramload;
            end
            if (isPeer[c] && peerHeld) begin
                cacheRsp[c].ccwait      = 1'b1;
                cacheRsp[c].ccinv       = (op == busPkg::opFill);
                cacheRsp[c].ccsnoopaddr = snoopAddr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/coherenceFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module coherenceFsm (
    input  wire                       CLK,
    input  wire                       nRST,
    input  wire busPkg::cacheReq_t    cacheReq [2],
    input  wire ramPkg::ramState_t    ramState,
    input  wire                       lastWord,
    output busPkg::busOp_t            op,
    output busPkg::coreSel_t          owner,
    output logic                      start,
    output logic                      step,
    output logic                      writeMiss
);

    typedef enum logic [2:0] {
        idle,
        snoop,
        flush,
        fill,
        fetch,
        writeBack
    } fsmState_t;

    fsmState_t        state;
    fsmState_t        nextState;
    busPkg::coreSel_t grantCore;
    busPkg::coreSel_t peer;
    logic             grantWrite;
    logic [1:0]       dataReq;
    logic             ramDone;
    logic             blockPhase;

    assign dataReq[0] = cacheReq[0].dREN || cacheReq[0].dWEN;
    assign dataReq[1] = cacheReq[1].dREN || cacheReq[1].dWEN;
    assign peer       = ~owner;
    assign ramDone    = (ramState == ramPkg::ramAccess);
    assign blockPhase = state inside {flush, fill, writeBack};

    always_comb begin
        nextState  = state;
        grantCore  = owner;
        grantWrite = 1'b0;
        case (state)
            idle: begin
                // data before instruction, core 0 before core 1
                if (dataReq != 2'b00) begin
                    grantCore  = dataReq[0] ? 1'b0 : 1'b1;
                    nextState  = cacheReq[grantCore].dWEN ? writeBack : snoop;
                    grantWrite = cacheReq[grantCore].ccwrite && !cacheReq[grantCore].dWEN;
                end else if (cacheReq[0].iREN || cacheReq[1].iREN) begin
                    grantCore = cacheReq[0].iREN ? 1'b0 : 1'b1;
                    nextState = fetch;
                end
            end
            snoop: begin
                // peer owns the block modified
                nextState = cacheReq[peer].cctrans ? flush : fill;
            end
            flush: begin
                if (ramDone && lastWord) begin
                    nextState = fill;
                end
            end
            fill, writeBack: begin
                if (ramDone && lastWord) begin
                    nextState = idle;
                end
            end
            fetch: begin
                if (ramDone) begin
                    nextState = idle;
                end
            end
            default: nextState = idle;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= idle;
            owner     <= 1'b0;
            writeMiss <= 1'b0;
        end else begin
            state <= nextState;
            if (state == idle && nextState != idle) begin
                owner     <= grantCore;
                writeMiss <= grantWrite;
            end
        end
    end

    // counter is cleared on the edge that enters a block phase
    assign start = (nextState != state) && (nextState inside {flush, fill, writeBack});
    assign step  = blockPhase && ramDone;

    always_comb begin
        case (state)
            snoop:     op = busPkg::opSnoop;
            flush:     op = busPkg::opFlush;
            fill:      op = busPkg::opFill;
            fetch:     op = busPkg::opFetch;
            writeBack: op = busPkg::opWriteBack;
            default:   op = busPkg::opNone;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/ramPkg.sv ====
`default_nettype none

package ramPkg;

    typedef enum logic [1:0] {
        ramFree,
        ramBusy,
        ramAccess,
        ramError
    } ramState_t;

    // one word request, held until ramAccess
    typedef struct packed {
        logic          ramREN;
        logic          ramWEN;
        busPkg::addr_t ramaddr;
        busPkg::word_t ramstore;
    } ramReq_t;

endpackage

`default_nettype wire

// ==== rtl/ramPortMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module ramPortMux #(
    parameter int BlockWords = 2,
    localparam int IdxW = (BlockWords > 1) ? $clog2(BlockWords) : 1
) (
    input  wire busPkg::busOp_t    op,
    input  wire busPkg::coreSel_t  owner,
    input  wire [IdxW-1:0]         wordIdx,
    input  wire busPkg::cacheReq_t cacheReq [2],
    output ramPkg::ramReq_t        ramReq
);

    // word field of the byte address
    localparam busPkg::addr_t IdxMask = busPkg::addr_t'((BlockWords - 1) << 2);

    busPkg::coreSel_t peer;
    busPkg::addr_t    wordAddr;

    assign peer     = ~owner;
    assign wordAddr = (cacheReq[owner].daddr & ~IdxMask)
                    | (busPkg::addr_t'(wordIdx) << 2);

    always_comb begin
        ramReq = '0;
        case (op)
            busPkg::opFetch: begin
                ramReq.ramREN  = 1'b1;
                ramReq.ramaddr = cacheReq[owner].iaddr;
            end
            busPkg::opFill: begin
                ramReq.ramREN  = 1'b1;
                ramReq.ramaddr = wordAddr;
            end
            busPkg::opFlush: begin
                // modified copy comes from the snooped core
                ramReq.ramWEN   = 1'b1;
                ramReq.ramaddr  = wordAddr;
                ramReq.ramstore = cacheReq[peer].dstore;
            end
            busPkg::opWriteBack: begin
                ramReq.ramWEN   = 1'b1;
                ramReq.ramaddr  = wordAddr;
                ramReq.ramstore = cacheReq[owner].dstore;
            end
            default: begin
                ramReq = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/wordCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wordCounter #(
    parameter int BlockWords = 2,
    localparam int IdxW = (BlockWords > 1) ? $clog2(BlockWords) : 1
) (
    input  wire             CLK,
    input  wire             nRST,
    input  wire             start,
    input  wire             step,
    output logic [IdxW-1:0] wordIdx,
    output logic            lastWord
);

    localparam logic [IdxW-1:0] LastIdx = IdxW'(BlockWords - 1);

    assign lastWord = (wordIdx == LastIdx);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wordIdx <= '0;
        end else if (start) begin
            wordIdx <= '0;
        end else if (step) begin
            // wrap after the last word of the block
            wordIdx <= lastWord ? '0 : wordIdx + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/busPkg.sv
rtl/ramPkg.sv
rtl/wordCounter.sv
rtl/coherenceFsm.sv
rtl/ramPortMux.sv
rtl/cacheResponder.sv
rtl/busController.sv
verif/busController_assert.sv
verif/tbBusController.sv

// ==== verif/busController_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module busControllerAssert (
    input wire                    CLK,
    input wire                    nRST,
    input wire busPkg::cacheReq_t cacheReq [2],
    input wire busPkg::cacheRsp_t cacheRsp [2],
    input wire ramPkg::ramReq_t   ramReq,
    input wire ramPkg::ramState_t ramState
);

    int exclusiveFails = 0;
    int invalidateFails = 0;
    int addrFails = 0;
    int failCount;

    assign failCount = exclusiveFails + invalidateFails + addrFails;

    // one RAM direction at a time, and only for a held request
    assert property (@(posedge CLK) disable iff (!nRST)
        !(ramReq.ramREN && ramReq.ramWEN)
        && (!ramReq.ramREN || cacheReq[0].iREN || cacheReq[1].iREN
            || cacheReq[0].dREN || cacheReq[1].dREN)
        && (!ramReq.ramWEN || cacheReq[0].dREN || cacheReq[1].dREN
            || cacheReq[0].dWEN || cacheReq[1].dWEN))
    else begin
        exclusiveFails++;
        $error("RAM enables do not match the pending requests");
    end

    // invalidate goes only to a stalled peer during a write-miss fill
    assert property (@(posedge CLK) disable iff (!nRST)
        (!cacheRsp[0].ccinv
            || (cacheRsp[0].ccwait && cacheReq[1].dREN && cacheReq[1].ccwrite))
        && (!cacheRsp[1].ccinv
            || (cacheRsp[1].ccwait && cacheReq[0].dREN && cacheReq[0].ccwrite)))
    else begin
        invalidateFails++;
        $error("ccinv without ccwait or without a write miss");
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        (ramState == ramPkg::ramBusy || ramState == ramPkg::ramAccess)
        |-> $stable(ramReq.ramaddr))
    else begin
        addrFails++;
        $error("RAM address changed during a pending access");
    end

endmodule

bind busController busControllerAssert i_assert (
    .CLK      (CLK),
    .nRST     (nRST),
    .cacheReq (cacheReq),
    .cacheRsp (cacheRsp),
    .ramReq   (ramReq),
    .ramState (ramState)
);

`default_nettype wire

// ==== verif/tbBusController.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbBusController;

    localparam int BlockWords = 2;
    localparam int MemWords = 256;
    localparam int TimeoutCycles = 6 * 4 * (2 + BlockWords) * 6 + 100;

    logic              CLK = 1'b0;
    logic              nRST;
    busPkg::cacheReq_t cacheReq [2];
    busPkg::cacheRsp_t cacheRsp [2];
    ramPkg::ramReq_t   ramReq;
    ramPkg::ramState_t ramState;
    busPkg::word_t     ramload;

    busPkg::word_t mem [MemWords];
    busPkg::word_t cacheData [2][MemWords];
    busPkg::word_t expBlock [BlockWords];
    logic          modified [2][MemWords / BlockWords];
    integer        seed = 32'h2627;
    int            draw;
    int            busyLeft;
    int            cycleCount = 0;

    busController #(.BlockWords(BlockWords)) i_dut (
        .CLK      (CLK),
        .nRST     (nRST),
        .cacheReq (cacheReq),
        .cacheRsp (cacheRsp),
        .ramReq   (ramReq),
        .ramState (ramState),
        .ramload  (ramload)
    );

    always #2 CLK = ~CLK;

    function automatic int memIdx(input busPkg::addr_t a);
        return int'(a[9:2]);
    endfunction

    function automatic int blockOf(input busPkg::addr_t a);
        return memIdx(a) / BlockWords;
    endfunction

    // every address bit reaches the word
    function automatic busPkg::word_t fillWord(input busPkg::addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    // word RAM, 0 to 3 busy cycles before each access
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ramState <= ramPkg::ramFree;
            ramload  <= '0;
            busyLeft <= 0;
            for (int i = 0; i < MemWords; i++) begin
                mem[i] <= fillWord(busPkg::addr_t'(i << 2));
            end
        end else if (ramState == ramPkg::ramAccess) begin
            if (ramReq.ramWEN) begin
                mem[memIdx(ramReq.ramaddr)] <= ramReq.ramstore;
            end
            ramState <= ramPkg::ramFree;
        end else if (ramState == ramPkg::ramBusy) begin
            if (busyLeft == 0) begin
                ramState <= ramPkg::ramAccess;
                ramload  <= mem[memIdx(ramReq.ramaddr)];
            end else begin
                busyLeft <= busyLeft - 1;
            end
        end else if (ramReq.ramREN || ramReq.ramWEN) begin
            draw = $random(seed) & 3;
            if (draw == 0) begin
                ramState <= ramPkg::ramAccess;
                ramload  <= mem[memIdx(ramReq.ramaddr)];
            end else begin
                ramState <= ramPkg::ramBusy;
                busyLeft <= draw - 1;
            end
        end
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (i_dut.i_assert.failCount != 0) begin
            $display("ERROR: a bound assertion failed");
            $display("STATUS: FAIL");
            $fatal(1, "assertion failure");
        end else if (cycleCount == TimeoutCycles) begin
            $display("ERROR: tests did not finish within %0d cycles", TimeoutCycles);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic failRun(input string what);
        $display("ERROR: %s", what);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareWord(input string test, input busPkg::word_t exp,
                               input busPkg::word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", test, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic compareAddr(input string test, input busPkg::addr_t exp,
                               input busPkg::addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", test, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic compareFlag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", test, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    // one edge, then both cache models answer as snooped peers
    task automatic tick();
        @(posedge CLK);
        for (int c = 0; c < 2; c++) begin
            cacheReq[c].cctrans <= cacheReq[1 - c].dREN
                && modified[c][blockOf(cacheReq[1 - c].daddr)];
            if (cacheRsp[c].ccwait) begin
                cacheReq[c].dstore <= cacheData[c][memIdx(cacheRsp[c].ccsnoopaddr)];
            end
            if (cacheRsp[c].ccinv) begin
                modified[c][blockOf(cacheRsp[c].ccsnoopaddr)] = 1'b0;
            end
        end
    endtask

    task automatic testReset();
        repeat (3) begin
            tick();
            for (int c = 0; c < 2; c++) begin
                compareFlag("reset iwait", 1'b0, cacheRsp[c].iwait);
                compareFlag("reset dwait", 1'b0, cacheRsp[c].dwait);
                compareFlag("reset ccwait", 1'b0, cacheRsp[c].ccwait);
                compareFlag("reset ccinv", 1'b0, cacheRsp[c].ccinv);
            end
            compareFlag("reset ramREN", 1'b0, ramReq.ramREN);
            compareFlag("reset ramWEN", 1'b0, ramReq.ramWEN);
        end
    endtask

    task automatic testFetch();
        busPkg::addr_t addr [2];
        int            left;
        int            first;
        addr[0] = 32'h0000_0040;
        addr[1] = 32'h0000_0084;
        left = 2;
        first = -1;
        for (int c = 0; c < 2; c++) begin
            cacheReq[c].iREN  <= 1'b1;
            cacheReq[c].iaddr <= addr[c];
        end
        while (left > 0) begin
            tick();
            for (int c = 0; c < 2; c++) begin
                if (cacheReq[c].iREN && !cacheRsp[c].iwait) begin
                    compareWord("fetch priority", fillWord(addr[c]), cacheRsp[c].iload);
                    cacheReq[c].iREN <= 1'b0;
                    left--;
                    if (first < 0) begin
                        first = c;
                    end
                end
            end
        end
        if (first != 0) begin
            failRun("fetch priority: core 1 was served before core 0");
        end
    endtask

    // data fill, peer side watched for snoop, flush and invalidate
    task automatic runFill(input string test, input int core, input busPkg::addr_t base,
                           input logic write, input int expFlush);
        int words;
        int flushed;
        int snoops;
        int peer;
        words = 0;
        flushed = 0;
        snoops = 0;
        peer = 1 - core;
        cacheReq[core].dREN    <= 1'b1;
        cacheReq[core].daddr   <= base;
        cacheReq[core].ccwrite <= write;
        while (words < BlockWords) begin
            tick();
            if (cacheRsp[peer].ccwait && !ramReq.ramREN && !ramReq.ramWEN) begin
                compareAddr({test, " snoop address"}, base, cacheRsp[peer].ccsnoopaddr);
                snoops++;
            end
            if (ramReq.ramWEN && ramState == ramPkg::ramAccess) begin
                compareAddr({test, " flush snoop address"},
                            base + busPkg::addr_t'(4 * flushed),
                            cacheRsp[peer].ccsnoopaddr);
                compareAddr({test, " flush address"}, base + busPkg::addr_t'(4 * flushed),
                            ramReq.ramaddr);
                compareWord({test, " flush data"}, cacheData[peer][memIdx(base) + flushed],
                            ramReq.ramstore);
                flushed++;
            end
            if (ramReq.ramREN) begin
                compareFlag({test, " peer ccwait"}, write, cacheRsp[peer].ccwait);
                compareFlag({test, " peer ccinv"}, write, cacheRsp[peer].ccinv);
            end
            if (!cacheRsp[core].dwait) begin
                compareWord({test, " dload"}, expBlock[words], cacheRsp[core].dload);
                words++;
            end
        end
        cacheReq[core].dREN    <= 1'b0;
        cacheReq[core].ccwrite <= 1'b0;
        if (snoops != 1 || flushed != expFlush) begin
            failRun($sformatf("%s: %0d snoop cycles and %0d flushed words, expected 1 and %0d",
                              test, snoops, flushed, expFlush));
        end
    endtask

    task automatic runWriteBack(input string test, input int core, input busPkg::addr_t base);
        int words;
        words = 0;
        cacheReq[core].dWEN   <= 1'b1;
        cacheReq[core].daddr  <= base;
        cacheReq[core].dstore <= expBlock[0];
        while (words < BlockWords) begin
            tick();
            compareFlag({test, " peer ccwait"}, 1'b0, cacheRsp[1 - core].ccwait);
            if (!cacheRsp[core].dwait) begin
                words++;
                if (words < BlockWords) begin
                    cacheReq[core].dstore <= expBlock[words];
                end
            end
        end
        cacheReq[core].dWEN <= 1'b0;
        tick();
        for (int k = 0; k < BlockWords; k++) begin
            compareWord(test, expBlock[k], mem[memIdx(base) + k]);
        end
    endtask

    initial begin
        nRST <= 1'b0;
        for (int c = 0; c < 2; c++) begin
            cacheReq[c] <= '0;
            for (int b = 0; b < MemWords / BlockWords; b++) begin
                modified[c][b] = 1'b0;
            end
        end
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;

        testReset();
        testFetch();

        for (int k = 0; k < BlockWords; k++) begin
            expBlock[k] = fillWord(busPkg::addr_t'(32'h100 + 4 * k));
        end
        runFill("clean read miss", 0, 32'h0000_0100, 1'b0, 0);

        // core 1 holds this block modified
        modified[1][blockOf(32'h0000_0180)] = 1'b1;
        for (int k = 0; k < BlockWords; k++) begin
            cacheData[1][memIdx(32'h0000_0180) + k] = 32'hD1A7_0000 + k;
            expBlock[k] = 32'hD1A7_0000 + k;
        end
        runFill("dirty read miss", 0, 32'h0000_0180, 1'b0, BlockWords);
        for (int k = 0; k < BlockWords; k++) begin
            compareWord("dirty read miss ram", expBlock[k], mem[memIdx(32'h0000_0180) + k]);
        end

        for (int k = 0; k < BlockWords; k++) begin
            expBlock[k] = fillWord(busPkg::addr_t'(32'h200 + 4 * k));
        end
        runFill("write miss", 1, 32'h0000_0200, 1'b1, 0);

        for (int k = 0; k < BlockWords; k++) begin
            expBlock[k] = 32'hB0B0_0000 + 32'h11 * k;
        end
        runWriteBack("writeback", 0, 32'h0000_0280);

        if (i_dut.i_assert.failCount == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("ERROR: %0d bound assertion failures", i_dut.i_assert.failCount);
            $display("STATUS: FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire
